// ==== ooo_core.f ====
src/ooo_pkg.sv
src/reservation_station.sv
src/int_alu.sv
src/pipelined_multiplier.sv
src/cdb_arbiter.sv
src/reorder_buffer.sv
src/rename_unit.sv
src/ooo_core.sv
sim/ooo_core_assertions.sv
sim/ooo_core_checker.sv
sim/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - src/ooo_pkg.sv
  - src/reservation_station.sv
  - src/int_alu.sv
  - src/pipelined_multiplier.sv
  - src/cdb_arbiter.sv
  - src/reorder_buffer.sv
  - src/rename_unit.sv
  - src/ooo_core.sv
  - target: simulation
    files:
      - sim/ooo_core_assertions.sv
      - sim/ooo_core_checker.sv
      - sim/ooo_core_tb.sv

// ==== sim/ooo_core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module ooo_core_tb;

    localparam int n_indep = 40;
    localparam int n_chain = 40;
    localparam int n_burst = 64;
    localparam int n_zero  = 24;
    localparam int n_total = n_indep + n_chain + n_burst + n_zero;
    // each op may wait behind a full rob and a multiply, plus reset and idle time
    localparam int watchdog_cycles =
        n_total * (ooo_pkg::rob_size + ooo_pkg::mult_stages + 4) + 100;

    logic                  clock;
    logic                  arst_n;
    logic                  dispatch_valid;
    ooo_pkg::dispatch_op_t dispatch_op;
    logic                  dispatch_ready;
    ooo_pkg::commit_t      commit;

    logic [31:0] rng_state = 32'h1737_fbbf;
    logic [31:0] model_regs [ooo_pkg::reg_num];   // architectural state of the model
    int          issued       = 0;
    int          stalls       = 0;                 // cycles with valid high, ready low
    int          tb_errors    = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    ooo_core dut_i (
        .clock(clock), .arst_n(arst_n),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_ready(dispatch_ready), .commit(commit)
    );

    ooo_core_checker checker_i (.clock(clock), .arst_n(arst_n), .commit(commit));

    always #50 clock = ~clock;

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic random_op(input int mult_pct, output ooo_pkg::dispatch_op_t op);
        logic [31:0] r;
        next_rand(r);
        op.fu_sel   = (r % 32'd100 < mult_pct) ? ooo_pkg::fu_mult : ooo_pkg::fu_alu;
        op.alu_func = ooo_pkg::alu_func_t'(r[10:8]);
        op.rd       = r[15:11];
        if (op.rd == '0)
            op.rd = 5'd1;              // x0 writes only in their own test
        op.rs1      = r[20:16];
        op.rs2      = r[25:21];
        op.use_imm  = r[26];
        next_rand(r);
        op.imm      = r[11:0];
    endtask

    // in-order interpreter, one op at a time
    function automatic logic [31:0] model_result(input ooo_pkg::dispatch_op_t op);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        a = model_regs[op.rs1];
        b = op.use_imm ? {{20{op.imm[11]}}, op.imm} : model_regs[op.rs2];
        if (op.fu_sel == ooo_pkg::fu_mult) begin
            prod = a * b;
            return prod[31:0];
        end
        case (op.alu_func)
            ooo_pkg::alu_add: return a + b;
            ooo_pkg::alu_sub: return a - b;
            ooo_pkg::alu_and: return a & b;
            ooo_pkg::alu_or:  return a | b;
            ooo_pkg::alu_xor: return a ^ b;
            ooo_pkg::alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::alu_sll: return a << b[4:0];
            ooo_pkg::alu_srl: return a >> b[4:0];
            default:          return 32'hxxxx_xxxx;
        endcase
    endfunction

    // called 10 ns after a rising edge, returns at the same phase
    task automatic send_op(input ooo_pkg::dispatch_op_t op);
        logic             accepted;
        ooo_pkg::commit_t exp_c;
        accepted       = 1'b0;
        dispatch_op    = op;           // held steady while stalled
        dispatch_valid = 1'b1;
        while (!accepted) begin
            @(negedge clock);
            accepted = dispatch_ready;
            if (!accepted)
                stalls++;
            @(posedge clock);
            #10;
        end
        exp_c.valid = 1'b1;
        exp_c.rd    = op.rd;
        exp_c.value = model_result(op);
        if (op.rd != '0)
            model_regs[op.rd] = exp_c.value;   // x0 stays zero
        checker_i.expect_commit(exp_c);
        dispatch_valid = 1'b0;
        issued++;
    endtask

    function automatic int error_total();
        return checker_i.error_count + dut_i.assert_i.fail_count + tb_errors;
    endfunction

    // drain, then one line per test
    task automatic finish_test(input string name, input int errors_before);
        while (checker_i.commit_count < issued)
            @(negedge clock);
        @(posedge clock);
        #10;
        if (error_total() == errors_before) begin
            tests_passed++;
            $display("test %s: ok, %0d ops committed so far", name, issued);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_total() - errors_before);
        end
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, %0d of %0d ops committed",
                 watchdog_cycles, checker_i.commit_count, issued);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////
    // tests
    //////////////////////////////
    initial begin
        ooo_pkg::dispatch_op_t op;
        ooo_pkg::reg_idx_t     prev_rd;
        int                    errors_before;
        clock          = 1'b0;
        arst_n         = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = '0;
        prev_rd        = 5'd1;
        for (int i = 0; i < ooo_pkg::reg_num; i++)
            model_regs[i] = '0;
        repeat (5) @(posedge clock);
        #10;
        arst_n = 1'b1;

        // idle core, nothing may retire
        errors_before = error_total();
        if (dispatch_ready !== 1'b1) begin
            $display("ERR %0t: dispatch_ready is %b after reset", $time, dispatch_ready);
            tb_errors++;
        end
        repeat (5) @(posedge clock);
        #10;
        if (checker_i.commit_count != 0) begin
            $display("commit port fired before any dispatch was accepted");
            tb_errors++;
        end
        finish_test("reset_idle", errors_before);

        errors_before = error_total();
        for (int i = 0; i < n_indep; i++) begin
            random_op(0, op);              // alu only
            send_op(op);
        end
        finish_test("independent_alu", errors_before);

        // each op reads the previous result, tag wakeup and bypass
        errors_before = error_total();
        for (int i = 0; i < n_chain; i++) begin
            random_op(40, op);
            op.rs1 = prev_rd;
            if (i % 2 == 0)
                op.rs2 = prev_rd;
            send_op(op);
            prev_rd = op.rd;
        end
        finish_test("dependent_chain", errors_before);

        // mostly chained multiplies, stations and rob back up
        errors_before = error_total();
        stalls        = 0;
        for (int i = 0; i < n_burst; i++) begin
            random_op(70, op);
            if (i % 4 != 0)
                op.rs1 = prev_rd;
            send_op(op);
            prev_rd = op.rd;
        end
        if (stalls == 0) begin
            $display("dispatch_ready never dropped during the burst, the core did not fill");
            tb_errors++;
        end
        finish_test("burst_stall", errors_before);

        errors_before = error_total();
        for (int i = 0; i < n_zero; i++) begin
            random_op(30, op);
            if (i % 3 == 0) begin
                op.rd = '0;                // write to x0, still commits
            end else begin
                op.rs1 = '0;
                if (i % 3 == 2)
                    op.rs2 = '0;
            end
            send_op(op);
        end
        finish_test("x0_zero", errors_before);

        $display("tests passed %0d, tests with errors %0d, total errors %0d",
                 tests_passed, tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ooo_core_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module ooo_core_checker (
    input logic             clock,
    input logic             arst_n,
    input ooo_pkg::commit_t commit
);

    ooo_pkg::commit_t expected_q [$];   // oldest first
    int               commit_count = 0;
    int               error_count  = 0;

    // model pushes here on every accepted dispatch
    task automatic expect_commit(input ooo_pkg::commit_t c);
        expected_q.push_back(c);
    endtask

    // commit is combinational off rob state, steady mid-cycle
    always @(negedge clock) begin : compare
        ooo_pkg::commit_t want;
        if (arst_n && commit.valid) begin
            commit_count++;
            if (expected_q.size() == 0) begin
                $display("unexpected commit at %0t: rd %0d retired with nothing dispatched",
                         $time, commit.rd);
                error_count++;
            end else begin
                want = expected_q.pop_front();
                if (commit.rd !== want.rd || commit.value !== want.value) begin
                    $display("ERR %0t: commit %0d rd %0d value %h, expected rd %0d value %h",
                             $time, commit_count, commit.rd, commit.value,
                             want.rd, want.value);
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/ooo_core_assertions.sv ====
`default_nettype none
`timescale 1ns/100ps

module ooo_core_assertions (
    input logic clock,
    input logic arst_n,
    input logic commit_valid,
    input logic cdb_valid,
    input logic alu_grant,
    input logic mult_valid
);

    int fail_count = 0;   // assertion failures so far

    commit_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(commit_valid))
    else begin
        $error("commit valid is unknown");
        fail_count++;
    end

    cdb_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(cdb_valid))
    else begin
        $error("bus valid is unknown");
        fail_count++;
    end

    // granted alu result lands next cycle, no product may land with it
    no_bus_clash: assert property (@(posedge clock) disable iff (!arst_n)
        alu_grant |=> !mult_valid)
    else begin
        $error("alu result and multiplier result reached the bus together");
        fail_count++;
    end

endmodule

bind ooo_core ooo_core_assertions assert_i (
    .clock(clock), .arst_n(arst_n),
    .commit_valid(commit.valid), .cdb_valid(cdb.valid),
    .alu_grant(alu_grant), .mult_valid(mult_result.valid)
);

`default_nettype wire

// ==== src/ooo_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module ooo_core (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  dispatch_valid,
    input  ooo_pkg::dispatch_op_t dispatch_op,
    output logic                  dispatch_ready,
    output ooo_pkg::commit_t      commit
);

    logic                                            alu_load, mult_load, alloc;
    logic                                            alu_full, mult_full, rob_full;
    ooo_pkg::operand_t                               src1, src2;
    ooo_pkg::rob_tag_t                               dest, alloc_tag;
    logic [ooo_pkg::rob_size-1:0]                    rob_done;
    logic [ooo_pkg::rob_size-1:0][ooo_pkg::xlen-1:0] rob_value;
    ooo_pkg::cdb_t                                   cdb;

    logic                     alu_issue_valid, alu_grant;
    ooo_pkg::alu_func_t       alu_func;
    logic [ooo_pkg::xlen-1:0] alu_a, alu_b;
    ooo_pkg::rob_tag_t        alu_tag;
    ooo_pkg::cdb_t            alu_result;

    logic                     mult_issue_valid, mult_due_next;
    logic [ooo_pkg::xlen-1:0] mult_a, mult_b;
    ooo_pkg::rob_tag_t        mult_tag;
    ooo_pkg::cdb_t            mult_result;

    //////////////////////////////
    // rename and stations
    //////////////////////////////
    rename_unit rename_i (
        .clock(clock), .arst_n(arst_n),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .alu_full(alu_full), .mult_full(mult_full), .rob_full(rob_full),
        .alloc_tag(alloc_tag), .rob_done(rob_done), .rob_value(rob_value),
        .cdb(cdb), .commit(commit),
        .dispatch_ready(dispatch_ready),
        .alu_load(alu_load), .mult_load(mult_load),
        .src1(src1), .src2(src2), .dest(dest), .alloc(alloc)
    );

    reservation_station #(.func_t(ooo_pkg::alu_func_t)) alu_rs (
        .clock(clock), .arst_n(arst_n),
        .load(alu_load), .func(dispatch_op.alu_func), .dest(dest),
        .src1(src1), .src2(src2), .cdb(cdb),
        .issue_en(alu_grant),                  // arbiter decides
        .full(alu_full), .issue_valid(alu_issue_valid), .issue_func(alu_func),
        .issue_a(alu_a), .issue_b(alu_b), .issue_tag(alu_tag)
    );

    reservation_station #(.func_t(ooo_pkg::mult_func_t)) mult_rs (
        .clock(clock), .arst_n(arst_n),
        .load(mult_load), .func(ooo_pkg::mul_lo), .dest(dest),
        .src1(src1), .src2(src2), .cdb(cdb),
        .issue_en(1'b1),                       // pipelined, always accepts
        .full(mult_full), .issue_valid(mult_issue_valid), .issue_func(),
        .issue_a(mult_a), .issue_b(mult_b), .issue_tag(mult_tag)
    );

    //////////////////////////////
    // execute and bus
    //////////////////////////////
    int_alu alu_i (
        .clock(clock), .arst_n(arst_n), .start(alu_grant),
        .func(alu_func), .a(alu_a), .b(alu_b), .tag(alu_tag),
        .result(alu_result)
    );

    pipelined_multiplier mult_i (
        .clock(clock), .arst_n(arst_n), .start(mult_issue_valid),
        .a(mult_a), .b(mult_b), .tag(mult_tag),
        .result(mult_result), .due_next(mult_due_next)
    );

    cdb_arbiter cdb_arb_i (
        .alu_ready(alu_issue_valid), .alu_result(alu_result),
        .mult_result(mult_result), .mult_due_next(mult_due_next),
        .alu_grant(alu_grant), .cdb(cdb)
    );

    reorder_buffer rob_i (
        .clock(clock), .arst_n(arst_n),
        .alloc(alloc), .alloc_rd(dispatch_op.rd), .cdb(cdb),
        .full(rob_full), .alloc_tag(alloc_tag),
        .entry_done(rob_done), .entry_value(rob_value),
        .commit(commit)
    );

endmodule

`default_nettype wire

// ==== src/rename_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module rename_unit (
    input  logic                                            clock,
    input  logic                                            arst_n,
    input  logic                                            dispatch_valid,
    input  ooo_pkg::dispatch_op_t                           dispatch_op,
    input  logic                                            alu_full,
    input  logic                                            mult_full,
    input  logic                                            rob_full,
    input  ooo_pkg::rob_tag_t                               alloc_tag,
    input  logic [ooo_pkg::rob_size-1:0]                    rob_done,
    input  logic [ooo_pkg::rob_size-1:0][ooo_pkg::xlen-1:0] rob_value,
    input  ooo_pkg::cdb_t                                   cdb,
    input  ooo_pkg::commit_t                                commit,
    output logic                                            dispatch_ready,
    output logic                                            alu_load,
    output logic                                            mult_load,
    output ooo_pkg::operand_t                               src1,
    output ooo_pkg::operand_t                               src2,
    output ooo_pkg::rob_tag_t                               dest,
    output logic                                            alloc
);

    logic [ooo_pkg::reg_num-1:0][ooo_pkg::xlen-1:0] arch_q;   // x0 stays zero
    logic [ooo_pkg::reg_num-1:0]                    busy_q;
    ooo_pkg::rob_tag_t [ooo_pkg::reg_num-1:0]       alias_q;  // producer tag
    ooo_pkg::rob_tag_t                              retire_tag_q; // tracks rob head
    logic                                           unit_full;
    logic                                           fire;

    // ready if idle register, finished rob entry, or on the bus right now
    function automatic ooo_pkg::operand_t resolve(input ooo_pkg::reg_idx_t r);
        ooo_pkg::operand_t op;
        op.tag   = alias_q[r];
        op.ready = 1'b1;
        if (!busy_q[r])
            op.value = arch_q[r];
        else if (rob_done[op.tag])
            op.value = rob_value[op.tag];
        else if (cdb.valid && cdb.tag == op.tag)
            op.value = cdb.value;
        else begin
            op.ready = 1'b0;
            op.value = '0;
        end
        return op;
    endfunction

    //////////////////////////////
    // dispatch
    //////////////////////////////
    assign unit_full      = (dispatch_op.fu_sel == ooo_pkg::fu_alu) ? alu_full : mult_full;
    assign dispatch_ready = !rob_full && !unit_full;
    assign fire           = dispatch_valid && dispatch_ready;
    assign alu_load       = fire && dispatch_op.fu_sel == ooo_pkg::fu_alu;
    assign mult_load      = fire && dispatch_op.fu_sel == ooo_pkg::fu_mult;
    assign alloc          = fire;
    assign dest           = alloc_tag;

    always_comb begin
        src1 = resolve(dispatch_op.rs1);
        if (dispatch_op.use_imm)
            src2 = '{ready: 1'b1, tag: '0,
                     value: {{(ooo_pkg::xlen-12){dispatch_op.imm[11]}}, dispatch_op.imm}};
        else
            src2 = resolve(dispatch_op.rs2);
    end

    //////////////////////////////
    // commit and alias update
    //////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            arch_q       <= '0;
            busy_q       <= '0;
            alias_q      <= '0;
            retire_tag_q <= '0;
        end else begin
            if (commit.valid) begin
                retire_tag_q <= retire_tag_q + 1'b1;
                if (commit.rd != '0)
                    arch_q[commit.rd] <= commit.value;
                if (alias_q[commit.rd] == retire_tag_q)
                    busy_q[commit.rd] <= 1'b0;   // no younger writer pending
            end
            // newer rename wins over same-cycle commit
            if (fire && dispatch_op.rd != '0) begin
                busy_q[dispatch_op.rd]  <= 1'b1;
                alias_q[dispatch_op.rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`default_nettype none
`timescale 1ns/100ps

module reorder_buffer (
    input  logic                                             clock,
    input  logic                                             arst_n,
    input  logic                                             alloc,
    input  ooo_pkg::reg_idx_t                                alloc_rd,
    input  ooo_pkg::cdb_t                                    cdb,
    output logic                                             full,
    output ooo_pkg::rob_tag_t                                alloc_tag,
    output logic [ooo_pkg::rob_size-1:0]                     entry_done,
    output logic [ooo_pkg::rob_size-1:0][ooo_pkg::xlen-1:0]  entry_value,
    output ooo_pkg::commit_t                                 commit
);

    ooo_pkg::rob_tag_t                    head_q;   // oldest
    ooo_pkg::rob_tag_t                    tail_q;   // next free
    logic [$clog2(ooo_pkg::rob_size+1)-1:0] count_q;
    ooo_pkg::reg_idx_t                    rd_q [ooo_pkg::rob_size];
    logic                                 retire;

    assign full      = count_q == ooo_pkg::rob_size;
    assign alloc_tag = tail_q;

    // head retires once its result is in
    assign retire = (count_q != '0) && entry_done[head_q];
    assign commit = '{valid: retire, rd: rd_q[head_q], value: entry_value[head_q]};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            entry_done <= '0;
        end else begin
            if (alloc) begin
                entry_done[tail_q] <= 1'b0;
                tail_q             <= tail_q + 1'b1;   // wraps
            end
            if (cdb.valid)
                entry_done[cdb.tag] <= 1'b1;           // never the tail entry
            if (retire)
                head_q <= head_q + 1'b1;
            case ({alloc, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;           // both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (alloc)
            rd_q[tail_q] <= alloc_rd;
        if (cdb.valid)
            entry_value[cdb.tag] <= cdb.value;
    end

endmodule

`default_nettype wire

// ==== src/cdb_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic          alu_ready,      // alu station has a ready entry
    input  ooo_pkg::cdb_t alu_result,
    input  ooo_pkg::cdb_t mult_result,
    input  logic          mult_due_next,
    output logic          alu_grant,
    output ooo_pkg::cdb_t cdb
);

    // alu lands one cycle after grant, so hold it off when a product lands then
    assign alu_grant = alu_ready && !mult_due_next;

    // multiplier first, fixed latency cannot wait
    always_comb begin
        cdb = alu_result;
        if (mult_result.valid)
            cdb = mult_result;
    end

endmodule

`default_nettype wire

// ==== src/pipelined_multiplier.sv ====
`default_nettype none
`timescale 1ns/100ps

module pipelined_multiplier (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic [ooo_pkg::xlen-1:0] a,
    input  logic [ooo_pkg::xlen-1:0] b,
    input  ooo_pkg::rob_tag_t        tag,
    output ooo_pkg::cdb_t            result,
    output logic                     due_next    // last stage valid next cycle
);

    logic [ooo_pkg::mult_stages-1:0] valid_q;
    ooo_pkg::rob_tag_t               tag_q  [ooo_pkg::mult_stages];
    logic [ooo_pkg::xlen-1:0]        prod_q [ooo_pkg::mult_stages]; // stage 0 holds low pp
    logic [ooo_pkg::xlen-1:0]        hi_q;                          // stage 0 high pp

    // valid bits shift, one op may enter every cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            valid_q <= '0;
        else
            valid_q <= {valid_q[ooo_pkg::mult_stages-2:0], start};
    end

    always_ff @(posedge clock) begin
        // stage 0 two half-width partial products, only the low word is kept
        prod_q[0] <= a * b[ooo_pkg::xlen/2-1:0];
        hi_q      <= a * b[ooo_pkg::xlen-1:ooo_pkg::xlen/2];
        tag_q[0]  <= tag;
        // stage 1 sums them
        prod_q[1] <= prod_q[0] + (hi_q << (ooo_pkg::xlen/2));
        for (int s = 2; s < ooo_pkg::mult_stages; s++)
            prod_q[s] <= prod_q[s-1];   // delay only
        for (int s = 1; s < ooo_pkg::mult_stages; s++)
            tag_q[s] <= tag_q[s-1];
    end

    assign due_next = valid_q[ooo_pkg::mult_stages-2];
    assign result   = '{valid: valid_q[ooo_pkg::mult_stages-1],
                        tag:   tag_q[ooo_pkg::mult_stages-1],
                        value: prod_q[ooo_pkg::mult_stages-1]};

endmodule

`default_nettype wire

// ==== src/int_alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module int_alu (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     start,
    input  ooo_pkg::alu_func_t       func,
    input  logic [ooo_pkg::xlen-1:0] a,
    input  logic [ooo_pkg::xlen-1:0] b,
    input  ooo_pkg::rob_tag_t        tag,
    output ooo_pkg::cdb_t            result
);

    logic [ooo_pkg::xlen-1:0] value_d;
    logic [ooo_pkg::xlen-1:0] value_q;
    ooo_pkg::rob_tag_t        tag_q;
    logic                     valid_q;

    always_comb begin
        case (func)
            ooo_pkg::alu_add: value_d = a + b;
            ooo_pkg::alu_sub: value_d = a - b;
            ooo_pkg::alu_and: value_d = a & b;
            ooo_pkg::alu_or:  value_d = a | b;
            ooo_pkg::alu_xor: value_d = a ^ b;
            ooo_pkg::alu_slt: value_d = {{(ooo_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ooo_pkg::alu_sll: value_d = a << b[4:0];   // shamt is low 5 bits
            ooo_pkg::alu_srl: value_d = a >> b[4:0];
            default:          value_d = a + b;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) valid_q <= 1'b0;
        else         valid_q <= start;
    end

    always_ff @(posedge clock) begin
        value_q <= value_d;
        tag_q   <= tag;
    end

    assign result = '{valid: valid_q, tag: tag_q, value: value_q}; // on the bus next cycle

endmodule

`default_nettype wire

// ==== src/reservation_station.sv ====
`default_nettype none
`timescale 1ns/100ps

module reservation_station #(
    parameter type func_t = ooo_pkg::alu_func_t,
    parameter int  depth  = ooo_pkg::rs_depth
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     load,        // from rename
    input  func_t                    func,
    input  ooo_pkg::rob_tag_t        dest,
    input  ooo_pkg::operand_t        src1,
    input  ooo_pkg::operand_t        src2,
    input  ooo_pkg::cdb_t            cdb,
    input  logic                     issue_en,    // unit can take an op
    output logic                     full,
    output logic                     issue_valid,
    output func_t                    issue_func,
    output logic [ooo_pkg::xlen-1:0] issue_a,
    output logic [ooo_pkg::xlen-1:0] issue_b,
    output ooo_pkg::rob_tag_t        issue_tag
);

    typedef struct packed {
        func_t             func;
        ooo_pkg::rob_tag_t dest;
        ooo_pkg::operand_t src1;
        ooo_pkg::operand_t src2;
    } entry_t;

    logic [depth-1:0]         valid_q;
    entry_t                   entry_q [depth];
    logic [depth-1:0]         ready;       // both operands captured
    logic [$clog2(depth)-1:0] free_idx;
    logic [$clog2(depth)-1:0] issue_idx;
    logic                     take;

    assign full = &valid_q;
    assign take = issue_valid && issue_en;

    // scan downwards so the lowest index wins
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = depth - 1; i >= 0; i--) begin
            ready[i] = valid_q[i] && entry_q[i].src1.ready && entry_q[i].src2.ready;
            if (!valid_q[i])
                free_idx = i[$clog2(depth)-1:0];
            if (ready[i]) begin
                issue_idx   = i[$clog2(depth)-1:0];
                issue_valid = 1'b1;
            end
        end
    end

    assign issue_func = entry_q[issue_idx].func;
    assign issue_a    = entry_q[issue_idx].src1.value;
    assign issue_b    = entry_q[issue_idx].src2.value;
    assign issue_tag  = entry_q[issue_idx].dest;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            if (take)
                valid_q[issue_idx] <= 1'b0;  // freed on issue
            if (load)
                valid_q[free_idx] <= 1'b1;   // rename never loads when full
        end
    end

    // tag snoop, stale entries may match too, harmless
    always_ff @(posedge clock) begin
        for (int i = 0; i < depth; i++) begin
            if (cdb.valid && !entry_q[i].src1.ready && entry_q[i].src1.tag == cdb.tag) begin
                entry_q[i].src1.ready <= 1'b1;
                entry_q[i].src1.value <= cdb.value;
            end
            if (cdb.valid && !entry_q[i].src2.ready && entry_q[i].src2.tag == cdb.tag) begin
                entry_q[i].src2.ready <= 1'b1;
                entry_q[i].src2.value <= cdb.value;
            end
        end
        if (load)
            entry_q[free_idx] <= '{func, dest, src1, src2}; // already bypassed by rename
    end

endmodule

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int xlen        = 32;
    localparam int reg_num     = 32;
    localparam int rob_size    = 8;   // must stay a power of two, tags wrap
    localparam int rs_depth    = 4;   // entries per station
    localparam int mult_stages = 3;   // at least 2

    typedef logic [$clog2(reg_num)-1:0]  reg_idx_t;
    typedef logic [$clog2(rob_size)-1:0] rob_tag_t;

    //////////////////////////////
    // encodings
    //////////////////////////////
    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_sel_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_sll, alu_srl
    } alu_func_t;

    typedef enum logic {
        mul_lo                        // low word of the product
    } mult_func_t;

    //////////////////////////////
    // bundles
    //////////////////////////////
    typedef struct packed {
        fu_sel_t   fu_sel;
        alu_func_t alu_func;           // ignored for the multiplier
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        logic      use_imm;            // imm replaces rs2
        logic [11:0] imm;              // sign-extended
    } dispatch_op_t;

    typedef struct packed {
        logic            ready;
        rob_tag_t        tag;          // producer while not ready
        logic [xlen-1:0] value;
    } operand_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        logic [xlen-1:0] value;
    } commit_t;

endpackage

`default_nettype wire
